//--- dv/dev_st_checker.sv
`timescale 1ns/10ps

module dev_st_checker
  import dev_st_pkg::*;
  import apb_reg_pkg::*;
(
  input  logic                      dev_st_clk,
  input  logic                      sys_reset_in,
  input  apb_req_t                  apb_req_i,
  input  phy_link_t [PHY_COUNT-1:0] phy_link_i,
  input  logic [TTS_RUN_WIDTH-1:0]  tts_bin_i,
  input  logic [TTS_HDR_WIDTH-1:0]  tts_gray_i,
  input  logic                      status_valid_i,
  input  dev_st_rec_t               status_rec_i,
  input  logic                      capture_en_i
);

  int err_cnt = 0;
  int test_cnt = 0;
  int pass_cnt = 0;
  int err_at_start = 0;

  logic [TTS_RUN_WIDTH-1:0] prev_bin;
  logic                     have_prev = 1'b0;
  logic [TTS_RUN_WIDTH-1:0] tts_m = '0;     // expected tts_bin_o
  logic                     en_m = 1'b0;    // CTRL enable as written
  logic                     sent_m = 1'b0;  // model of the sent flag
  logic                     down_m = 1'b0;  // model of the registered all-down flag
  logic                     cap_m = 1'b0;   // expected capture_en_o
  logic [TTS_RUN_WIDTH-1:0] last_run;
  longint                   last_cycle;
  logic                     have_rec = 1'b0;
  longint                   cycle = 0;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("[ERROR] %s", msg);
    err_cnt++;
  endtask

  task automatic begin_test();
    err_at_start = err_cnt;
  endtask

  task automatic end_test(input int idx, input string name);
    test_cnt++;
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %0d %s: pass", idx, name);
    end else begin
      $display("test %0d %s: fail", idx, name);
    end
  endtask

  task automatic report_counts();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt);
  endtask

  // gray code built bit by bit from neighbouring binary bits
  function automatic logic [TTS_HDR_WIDTH-1:0] to_gray(input logic [TTS_HDR_WIDTH-1:0] b);
    logic [TTS_HDR_WIDTH-1:0] g;
    g[TTS_HDR_WIDTH-1] = b[TTS_HDR_WIDTH-1];
    for (int i = 0; i < TTS_HDR_WIDTH - 1; i++) begin
      g[i] = b[i] ^ b[i+1];
    end
    return g;
  endfunction

  // --------------------
  // per cycle checks
  always @(posedge dev_st_clk) begin
    cycle++;
    if (!sys_reset_in) begin
      check_value("tts_bin_o", tts_bin_i, tts_m);
    end
    if (!sys_reset_in && have_prev) begin
      check_value("tts_gray_o", 64'(tts_gray_i), 64'(to_gray(prev_bin[TTS_HDR_WIDTH-1:0])));
    end
    prev_bin  = tts_bin_i;
    have_prev = 1'b1;

    if (!sys_reset_in) begin
      check_value("capture_en_o", 64'(capture_en_i), 64'(cap_m));
    end
    cap_m  = sys_reset_in ? 1'b0 : (en_m & sent_m);
    sent_m = (sys_reset_in || down_m) ? 1'b0 : (status_valid_i ? 1'b1 : sent_m);
    down_m = 1'b1;
    for (int k = 0; k < PHY_COUNT; k++) begin
      if (phy_link_i[k].ready) down_m = 1'b0;
    end
    if (sys_reset_in) begin
      en_m = 1'b0;
    end else if (apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
                 apb_req_i.paddr == REG_CTRL) begin
      en_m = apb_req_i.pwdata[CTRL_EN_BIT];
    end

    // record contents on every pulse
    if (!sys_reset_in && status_valid_i) begin
      check_value("status_rec_o.rec_len", 64'(status_rec_i.rec_len), 64'd21);
      check_value("status_rec_o.version", 64'(status_rec_i.version), 64'd1);
      check_value("status_rec_o.tts_len", 64'(status_rec_i.tts_len), 64'd7);
      check_value("status_rec_o.tts_run", status_rec_i.tts_run, tts_m - 64'd1);
      if (have_rec) begin
        check_value("tts_run delta", status_rec_i.tts_run - last_run,
                    64'(cycle - last_cycle));
      end
      last_run   = status_rec_i.tts_run;
      last_cycle = cycle;
      have_rec   = 1'b1;
    end

    tts_m = sys_reset_in ? '0 : tts_m + 64'd1;  // counts from zero once reset drops
  end

endmodule

//--- dv/dev_st_tb.sv
`timescale 1ns/10ps

module dev_st_tb
  import dev_st_pkg::*;
  import apb_reg_pkg::*;
();

  typedef enum int {ST_WRITE, ST_READ, ST_LINK, ST_JOIN, ST_WAIT} step_kind_t;

  typedef struct {
    step_kind_t  kind;
    logic [7:0]  addr;
    logic [63:0] data;    // write data or link inputs
    logic [63:0] exp;     // read data, link states or serial number
    logic        err;
    int          window;  // cycles allowed for the step
    string       name;
  } step_t;

  logic                      dev_st_clk;
  logic                      sys_reset_in;
  apb_req_t                  apb_req;
  apb_rsp_t                  apb_rsp;
  phy_link_t [PHY_COUNT-1:0] phy_link;
  logic                      mg_join;
  link_st_t  [PHY_COUNT-1:0] link_st;
  logic [TTS_RUN_WIDTH-1:0]  tts_bin;
  logic [TTS_HDR_WIDTH-1:0]  tts_gray;
  logic                      status_valid;
  dev_st_rec_t               status_rec;
  logic                      capture_en;

  step_t       steps[$];
  logic [63:0] sn_a;
  logic [63:0] sn_b;
  int          limit;

  tb_clk_gen u_clk_gen (
    .dev_st_clk   (dev_st_clk),
    .sys_reset_in (sys_reset_in)
  );

  dev_st_top uut (
    .dev_st_clk     (dev_st_clk),
    .sys_reset_in   (sys_reset_in),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .phy_link_i     (phy_link),
    .mg_join_i      (mg_join),
    .link_st_o      (link_st),
    .tts_bin_o      (tts_bin),
    .tts_gray_o     (tts_gray),
    .status_valid_o (status_valid),
    .status_rec_o   (status_rec),
    .capture_en_o   (capture_en)
  );

  dev_st_checker u_chk (
    .dev_st_clk     (dev_st_clk),
    .sys_reset_in   (sys_reset_in),
    .apb_req_i      (apb_req),
    .phy_link_i     (phy_link),
    .tts_bin_i      (tts_bin),
    .tts_gray_i     (tts_gray),
    .status_valid_i (status_valid),
    .status_rec_i   (status_rec),
    .capture_en_i   (capture_en)
  );

  function automatic void add_step(input step_kind_t kind, input logic [7:0] addr,
                                   input logic [63:0] data, input logic [63:0] exp,
                                   input logic err, input int window, input string name);
    step_t s;
    s.kind   = kind;
    s.addr   = addr;
    s.data   = data;
    s.exp    = exp;
    s.err    = err;
    s.window = window;
    s.name   = name;
    steps.push_back(s);
  endfunction

  // --------------------
  // APB and pin drivers
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
    @(posedge dev_st_clk);
    #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge dev_st_clk);
    #1 apb_req.penable = 1'b1;
    #1;
    u_chk.check_value("apb_rsp_o.pready", 64'(apb_rsp.pready), 64'd1);
    u_chk.check_value("apb_rsp_o.pslverr", 64'(apb_rsp.pslverr), 64'(err));
    @(posedge dev_st_clk);
    #1 apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input logic err);
    @(posedge dev_st_clk);
    #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge dev_st_clk);
    #1 apb_req.penable = 1'b1;
    #1;
    u_chk.check_value("apb_rsp_o.pready", 64'(apb_rsp.pready), 64'd1);
    u_chk.check_value("apb_rsp_o.pslverr", 64'(apb_rsp.pslverr), 64'(err));
    if (!err) u_chk.check_value("apb_rsp_o.prdata", 64'(apb_rsp.prdata), 64'(exp));
    @(posedge dev_st_clk);
    #1 apb_req = '0;
  endtask

  task automatic set_links(input logic [5:0] links, input logic [3:0] exp);
    @(posedge dev_st_clk);
    #1 phy_link = links;
    #1 u_chk.check_value("link_st_o", 64'(link_st), 64'(exp));  // combinational
  endtask

  task automatic pulse_join();
    @(posedge dev_st_clk);
    #1 mg_join = 1'b1;
    #3 mg_join = 1'b0;  // much shorter than a clock period
  endtask

  task automatic wait_status(input int window, input logic [63:0] exp_sn);
    int n;
    logic found;
    n = 0;
    found = 1'b0;
    while (!found && n < window) begin
      @(posedge dev_st_clk);
      #1;
      n++;
      if (status_valid) found = 1'b1;
    end
    if (!found) begin
      u_chk.note_failure($sformatf("no status record within %0d cycles", window));
    end else begin
      u_chk.check_value("status_rec_o.dev_sn", status_rec.dev_sn, exp_sn);
    end
  endtask

  initial begin
    apb_req  = '0;
    phy_link = 6'b110_110;  // both PHYs up at 1G
    mg_join  = 1'b0;
    void'($urandom(32'h30f1_5380));
    sn_a = {$urandom, $urandom};
    sn_b = {$urandom, $urandom};

    // --------------------
    // step table
    add_step(ST_WAIT, 0, 0, 0, 0, INTERVAL_CNT + 2, "first periodic record");
    add_step(ST_WAIT, 0, 0, 0, 0, INTERVAL_CNT + 2, "second periodic record");
    add_step(ST_WRITE, REG_SN_LO, sn_a[31:0], 0, 0, 4, "write sn low");
    add_step(ST_WRITE, REG_SN_HI, sn_a[63:32], 0, 0, 4, "write sn high");
    add_step(ST_READ, REG_SN_LO, 0, sn_a[31:0], 0, 4, "read sn low");
    add_step(ST_READ, REG_SN_HI, 0, sn_a[63:32], 0, 4, "read sn high");
    add_step(ST_READ, 8'h10, 0, 0, 1, 4, "unmapped read");
    add_step(ST_WRITE, REG_CTRL, 1, 0, 0, 4, "enable capture");
    add_step(ST_READ, REG_CTRL, 0, 1, 0, 4, "read ctrl enabled");
    add_step(ST_READ, REG_STATUS, 0, 64'h29, 0, 4, "status two 1G links");
    add_step(ST_WRITE, REG_STATUS, 0, 0, 1, 4, "write to status");
    add_step(ST_WRITE, REG_CTRL, 3, 0, 0, 4, "force resend");
    add_step(ST_WAIT, 0, 0, sn_a, 0, FORCE_CNT + 3, "record after force");
    add_step(ST_JOIN, 0, 0, 0, 0, 2, "join pulse");
    add_step(ST_WAIT, 0, 0, sn_a, 0, 6, "record after join");
    add_step(ST_LINK, 0, 6'b101_110, 4'b0110, 0, 2, "phy1 to 100M");
    add_step(ST_WAIT, 0, 0, sn_a, 0, DELAY_CNT + 3, "record after link change");
    add_step(ST_READ, REG_STATUS, 0, 64'h19, 0, 4, "status mixed links");
    add_step(ST_LINK, 0, 6'b000_000, 4'b0000, 0, 2, "all links down");
    add_step(ST_READ, REG_STATUS, 0, 64'h00, 0, 4, "status all down");
    add_step(ST_LINK, 0, 6'b110_110, 4'b1010, 0, 2, "links back at 1G");
    add_step(ST_WAIT, 0, 0, sn_a, 0, DELAY_CNT + 3, "record after link up");
    add_step(ST_WRITE, REG_SN_LO, sn_b[31:0], 0, 0, 4, "write new sn low");
    add_step(ST_WRITE, REG_SN_HI, sn_b[63:32], 0, 0, 4, "write new sn high");
    add_step(ST_WRITE, REG_CTRL, 3, 0, 0, 4, "force with new sn");
    add_step(ST_WAIT, 0, 0, sn_b, 0, FORCE_CNT + 3, "record with new sn");
    add_step(ST_WRITE, REG_CTRL, 0, 0, 0, 4, "disable capture");
    add_step(ST_READ, REG_CTRL, 0, 0, 0, 4, "read ctrl disabled");

    limit = 50;  // reset and margin
    foreach (steps[i]) limit += steps[i].window;

    fork
      begin
        repeat (limit) @(posedge dev_st_clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
      end
    join_none

    @(negedge sys_reset_in);
    u_chk.begin_test();
    u_chk.check_value("status_valid_o", 64'(status_valid), 64'd0);
    u_chk.check_value("capture_en_o", 64'(capture_en), 64'd0);
    u_chk.check_value("apb_rsp_o.pslverr", 64'(apb_rsp.pslverr), 64'd0);
    u_chk.end_test(0, "outputs after reset");

    foreach (steps[i]) begin
      u_chk.begin_test();
      case (steps[i].kind)
        ST_WRITE: apb_write(steps[i].addr, steps[i].data[31:0], steps[i].err);
        ST_READ:  apb_read(steps[i].addr, steps[i].exp[31:0], steps[i].err);
        ST_LINK:  set_links(steps[i].data[5:0], steps[i].exp[3:0]);
        ST_JOIN:  pulse_join();
        default:  wait_status(steps[i].window, steps[i].exp);
      endcase
      u_chk.end_test(i + 1, steps[i].name);
    end

    repeat (4) @(posedge dev_st_clk);
    u_chk.report_counts();
    if (u_chk.err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic dev_st_clk,
  output logic sys_reset_in
);

  localparam real HALF_PERIOD = 10.0;  // 20 ns clock

  initial begin
    dev_st_clk   = 1'b0;
    sys_reset_in = 1'b1;
    repeat (4) @(posedge dev_st_clk);
    #1 sys_reset_in = 1'b0;
  end

  always #(HALF_PERIOD) dev_st_clk = ~dev_st_clk;

endmodule

//--- files.f
hdl/dev_st_pkg.sv
hdl/apb_reg_pkg.sv
hdl/tts_counter.sv
hdl/link_monitor.sv
hdl/status_scheduler.sv
hdl/status_record_builder.sv
hdl/apb_cfg_regs.sv
hdl/dev_st_top.sv
dv/tb_clk_gen.sv
dv/dev_st_checker.sv
dv/dev_st_tb.sv

//--- hdl/apb_cfg_regs.sv
`timescale 1ns/10ps

module apb_cfg_regs
  import dev_st_pkg::*;
  import apb_reg_pkg::*;
(
  input  logic                     dev_st_clk,
  input  logic                     sys_reset_in,
  input  apb_req_t                 apb_req_i,
  output apb_rsp_t                 apb_rsp_o,
  input  logic                     dev_info_sent_i,
  input  link_st_t [PHY_COUNT-1:0] link_st_i,
  output logic [DEV_SN_WIDTH-1:0]  dev_sn_o,
  output logic                     cfg_capture_en_o,
  output logic                     force_resend_o
);

  logic                      access;    // APB access phase
  logic                      wr_en;
  logic                      addr_hit;
  logic                      ro_write;  // write to read-only status
  logic [APB_DATA_WIDTH-1:0] status_word;
  logic [APB_DATA_WIDTH-1:0] rdata;

  assign access   = apb_req_i.psel & apb_req_i.penable;
  assign wr_en    = access & apb_req_i.pwrite;
  assign ro_write = apb_req_i.pwrite & (apb_req_i.paddr == REG_STATUS);

  always_comb begin
    status_word = '0;
    status_word[STATUS_SENT_BIT] = dev_info_sent_i;
    for (int k = 0; k < PHY_COUNT; k++) begin
      status_word[STATUS_LINK_LSB + 2*k +: 2] = link_st_i[k];
    end
  end

  // --------------------
  // read decode, zero wait states
  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req_i.paddr)
      REG_CTRL:   rdata[CTRL_EN_BIT] = cfg_capture_en_o;  // force bit reads 0
      REG_SN_LO:  rdata = dev_sn_o[APB_DATA_WIDTH-1:0];
      REG_SN_HI:  rdata = dev_sn_o[DEV_SN_WIDTH-1:APB_DATA_WIDTH];
      REG_STATUS: rdata = status_word;
      default:    addr_hit = 1'b0;
    endcase
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.prdata  = rdata;
    apb_rsp_o.pslverr = access & (~addr_hit | ro_write);
  end

  // --------------------
  // writes
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      dev_sn_o         <= '0;
      cfg_capture_en_o <= 1'b0;
      force_resend_o   <= 1'b0;
    end else begin
      force_resend_o <= wr_en & (apb_req_i.paddr == REG_CTRL) &
                        apb_req_i.pwdata[CTRL_FORCE_BIT];  // one cycle only
      if (wr_en) begin
        case (apb_req_i.paddr)
          REG_CTRL:  cfg_capture_en_o <= apb_req_i.pwdata[CTRL_EN_BIT];
          REG_SN_LO: dev_sn_o[APB_DATA_WIDTH-1:0] <= apb_req_i.pwdata;
          REG_SN_HI: dev_sn_o[DEV_SN_WIDTH-1:APB_DATA_WIDTH] <= apb_req_i.pwdata;
          default: begin
          end
        endcase
      end
    end
  end

  a_penable_in_sel: assert property (@(posedge dev_st_clk) disable iff (sys_reset_in)
    apb_req_i.penable |-> apb_req_i.psel);

endmodule

//--- hdl/apb_reg_pkg.sv
package apb_reg_pkg;

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                      pready;
    logic                      pslverr;
    logic [APB_DATA_WIDTH-1:0] prdata;
  } apb_rsp_t;

  // --------------------
  // register map
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_SN_LO  = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_SN_HI  = 8'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h0C;  // read only

  localparam int CTRL_EN_BIT     = 0;
  localparam int CTRL_FORCE_BIT  = 1;  // write one, self clearing
  localparam int STATUS_SENT_BIT = 0;
  localparam int STATUS_LINK_LSB = 2;  // two bits per PHY from here up

endpackage

//--- hdl/dev_st_pkg.sv
package dev_st_pkg;

  localparam int BYTE_WIDTH = 8;
  localparam int PHY_COUNT  = 2;

  // --------------------
  // timestamp and serial number sizes
  localparam int TTS_RUN_LENGTH = 8;  // running tts, tells a restart apart
  localparam int TTS_HDR_LENGTH = 7;  // tts carried in capture headers
  localparam int TTS_RUN_WIDTH  = TTS_RUN_LENGTH * BYTE_WIDTH;
  localparam int TTS_HDR_WIDTH  = TTS_HDR_LENGTH * BYTE_WIDTH;
  localparam int DEV_SN_LENGTH  = 8;
  localparam int DEV_SN_WIDTH   = DEV_SN_LENGTH * BYTE_WIDTH;

  localparam int DEV_ST_VERSION    = 1;
  localparam int DEV_ST_REC_LENGTH = 21;  // 2 + 2 + 8 + 1 + 8 bytes

  // --------------------
  // scheduler reload counts, in dev_st_clk cycles
  localparam int INTERVAL_CNT = 2000;  // periodic resend
  localparam int DELAY_CNT    = 200;   // settle time after a link change
  localparam int FORCE_CNT    = 20;
  localparam int CNT_WIDTH    = $clog2(INTERVAL_CNT + 1);

  typedef struct packed {
    logic ready;
    logic is_1g;
    logic is_100m;
  } phy_link_t;

  typedef enum logic [1:0] {
    LINK_DOWN  = 2'b00,
    LINK_100M  = 2'b01,
    LINK_1G    = 2'b10,
    LINK_OTHER = 2'b11
  } link_st_t;

  // field order is the byte order on the wire
  typedef struct packed {
    logic [15:0]              rec_len;
    logic [15:0]              version;
    logic [DEV_SN_WIDTH-1:0]  dev_sn;
    logic [7:0]               tts_len;
    logic [TTS_RUN_WIDTH-1:0] tts_run;
  } dev_st_rec_t;

endpackage

//--- hdl/dev_st_top.sv
`timescale 1ns/10ps

module dev_st_top
  import dev_st_pkg::*;
  import apb_reg_pkg::*;
(
  input  logic                      dev_st_clk,
  input  logic                      sys_reset_in,
  input  apb_req_t                  apb_req_i,
  output apb_rsp_t                  apb_rsp_o,
  input  phy_link_t [PHY_COUNT-1:0] phy_link_i,
  input  logic                      mg_join_i,   // async, may be very short
  output link_st_t  [PHY_COUNT-1:0] link_st_o,
  output logic [TTS_RUN_WIDTH-1:0]  tts_bin_o,
  output logic [TTS_HDR_WIDTH-1:0]  tts_gray_o,
  output logic                      status_valid_o,
  output dev_st_rec_t               status_rec_o,
  output logic                      capture_en_o
);

  logic [DEV_SN_WIDTH-1:0] dev_sn;
  logic                    cfg_capture_en;
  logic                    force_resend;
  logic                    link_changed;
  logic                    all_down;
  logic                    dev_info_sent;

  tts_counter u_tts_counter (
    .dev_st_clk   (dev_st_clk),
    .sys_reset_in (sys_reset_in),
    .tts_bin_o    (tts_bin_o),
    .tts_gray_o   (tts_gray_o)
  );

  link_monitor u_link_monitor (
    .dev_st_clk     (dev_st_clk),
    .sys_reset_in   (sys_reset_in),
    .phy_link_i     (phy_link_i),
    .link_st_o      (link_st_o),
    .link_changed_o (link_changed),
    .all_down_o     (all_down)
  );

  status_scheduler u_status_scheduler (
    .dev_st_clk      (dev_st_clk),
    .sys_reset_in    (sys_reset_in),
    .link_changed_i  (link_changed),
    .all_down_i      (all_down),
    .force_resend_i  (force_resend),
    .mg_join_i       (mg_join_i),
    .status_valid_o  (status_valid_o),
    .dev_info_sent_o (dev_info_sent)
  );

  status_record_builder u_status_record_builder (
    .dev_st_clk     (dev_st_clk),
    .sys_reset_in   (sys_reset_in),
    .status_valid_i (status_valid_o),
    .dev_sn_i       (dev_sn),
    .tts_bin_i      (tts_bin_o),
    .status_rec_o   (status_rec_o)
  );

  apb_cfg_regs u_apb_cfg_regs (
    .dev_st_clk       (dev_st_clk),
    .sys_reset_in     (sys_reset_in),
    .apb_req_i        (apb_req_i),
    .apb_rsp_o        (apb_rsp_o),
    .dev_info_sent_i  (dev_info_sent),
    .link_st_i        (link_st_o),
    .dev_sn_o         (dev_sn),
    .cfg_capture_en_o (cfg_capture_en),
    .force_resend_o   (force_resend)
  );

  // no captured packets before the device info record
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      capture_en_o <= 1'b0;
    end else begin
      capture_en_o <= cfg_capture_en & dev_info_sent;
    end
  end

endmodule

//--- hdl/link_monitor.sv
`timescale 1ns/10ps

module link_monitor
  import dev_st_pkg::*;
(
  input  logic                      dev_st_clk,
  input  logic                      sys_reset_in,
  input  phy_link_t [PHY_COUNT-1:0] phy_link_i,
  output link_st_t  [PHY_COUNT-1:0] link_st_o,
  output logic                      link_changed_o,
  output logic                      all_down_o
);

  logic     [PHY_COUNT-1:0] ready_vec;
  link_st_t [PHY_COUNT-1:0] link_st_q;  // state seen one cycle ago

  // --------------------
  // per PHY encoding
  always_comb begin
    for (int i = 0; i < PHY_COUNT; i++) begin
      ready_vec[i] = phy_link_i[i].ready;
      if (!phy_link_i[i].ready) begin
        link_st_o[i] = LINK_DOWN;
      end else if (phy_link_i[i].is_1g) begin
        link_st_o[i] = LINK_1G;
      end else if (phy_link_i[i].is_100m) begin
        link_st_o[i] = LINK_100M;
      end else begin
        link_st_o[i] = LINK_OTHER;  // 10M or unknown
      end
    end
  end

  // --------------------
  // change detect
  always_ff @(posedge dev_st_clk) begin
    link_st_q  <= link_st_o;  // tracks the input in reset too, no pulse on release
    all_down_o <= ~|ready_vec;
  end

  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      link_changed_o <= 1'b0;
    end else begin
      link_changed_o <= (link_st_q != link_st_o);  // single cycle, copy catches up
    end
  end

endmodule

//--- hdl/status_record_builder.sv
`timescale 1ns/10ps

module status_record_builder
  import dev_st_pkg::*;
(
  input  logic                     dev_st_clk,
  input  logic                     sys_reset_in,
  input  logic                     status_valid_i,
  input  logic [DEV_SN_WIDTH-1:0]  dev_sn_i,
  input  logic [TTS_RUN_WIDTH-1:0] tts_bin_i,
  output dev_st_rec_t              status_rec_o
);

  logic [TTS_RUN_WIDTH-1:0] tts_prev;  // tts of the cycle before
  logic [TTS_RUN_WIDTH-1:0] held_tts;
  logic [DEV_SN_WIDTH-1:0]  held_sn;

  always_ff @(posedge dev_st_clk) begin
    tts_prev <= tts_bin_i;
  end

  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      held_tts <= '0;
      held_sn  <= '0;
    end else if (status_valid_i) begin
      held_tts <= tts_prev;
      held_sn  <= dev_sn_i;
    end
  end

  // live fields during the pulse, so the record changes with the valid edge
  always_comb begin
    status_rec_o.rec_len = 16'(DEV_ST_REC_LENGTH);
    status_rec_o.version = 16'(DEV_ST_VERSION);
    status_rec_o.tts_len = 8'(TTS_HDR_LENGTH);
    status_rec_o.dev_sn  = status_valid_i ? dev_sn_i : held_sn;
    status_rec_o.tts_run = status_valid_i ? tts_prev : held_tts;
  end

endmodule

//--- hdl/status_scheduler.sv
`timescale 1ns/10ps

module status_scheduler
  import dev_st_pkg::*;
(
  input  logic dev_st_clk,
  input  logic sys_reset_in,
  input  logic link_changed_i,
  input  logic all_down_i,
  input  logic force_resend_i,
  input  logic mg_join_i,
  output logic status_valid_o,
  output logic dev_info_sent_o
);

  logic [CNT_WIDTH-1:0] cnt;
  logic                 join_meta;  // set straight from the pulse
  logic                 join_sync;
  logic                 join_seen;  // edge register
  logic                 join_edge;
  logic                 fire;

  // --------------------
  // join pulse into dev_st_clk
  // the async set catches a pulse shorter than our period
  always_ff @(posedge dev_st_clk or posedge mg_join_i) begin
    if (mg_join_i) begin
      join_meta <= 1'b1;
    end else begin
      join_meta <= 1'b0;
    end
  end

  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      join_sync <= 1'b0;
      join_seen <= 1'b0;
    end else begin
      join_sync <= join_meta;
      join_seen <= join_sync;
    end
  end

  assign join_edge = join_sync & ~join_seen;
  assign fire      = (cnt == '0) | (join_edge & ~status_valid_o);  // join right after a pulse is dropped

  // --------------------
  // reload countdown, force beats delay beats the interval reload
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      cnt            <= CNT_WIDTH'(INTERVAL_CNT);
      status_valid_o <= 1'b0;
    end else begin
      status_valid_o <= fire;
      if (force_resend_i) begin
        cnt <= CNT_WIDTH'(FORCE_CNT);
      end else if (link_changed_i) begin
        cnt <= CNT_WIDTH'(DELAY_CNT);
      end else if (fire) begin
        cnt <= CNT_WIDTH'(INTERVAL_CNT);
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // capture stays off until a record went out with a link up
  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in || all_down_i) begin
      dev_info_sent_o <= 1'b0;
    end else if (status_valid_o) begin
      dev_info_sent_o <= 1'b1;
    end
  end

  a_valid_single: assert property (@(posedge dev_st_clk) disable iff (sys_reset_in)
    status_valid_o |=> !status_valid_o);

endmodule

//--- hdl/tts_counter.sv
`timescale 1ns/10ps

module tts_counter
  import dev_st_pkg::*;
(
  input  logic                     dev_st_clk,
  input  logic                     sys_reset_in,
  output logic [TTS_RUN_WIDTH-1:0] tts_bin_o,
  output logic [TTS_HDR_WIDTH-1:0] tts_gray_o
);

  logic [TTS_HDR_WIDTH-1:0] tts_hdr;

  assign tts_hdr = tts_bin_o[TTS_HDR_WIDTH-1:0];

  always_ff @(posedge dev_st_clk) begin
    if (sys_reset_in) begin
      tts_bin_o  <= '0;
      tts_gray_o <= '0;
    end else begin
      tts_bin_o  <= tts_bin_o + 1'b1;
      tts_gray_o <= tts_hdr ^ (tts_hdr >> 1);  // gray of the previous count
    end
  end

  // the gray copy holds still for one cycle after reset, then moves one bit per cycle
  a_gray_one_bit: assert property (@(posedge dev_st_clk) disable iff (sys_reset_in)
    !$past(sys_reset_in) && !$past(sys_reset_in, 2) |->
      $onehot(tts_gray_o ^ $past(tts_gray_o)));

endmodule
